// File: hw/game_params.svh
//----------------------------------------------------------
// screen areas, queue depth and round limits of the game
// include in any file that needs the rectangles or limits
// the graphics layer draws from the same rectangle values
//----------------------------------------------------------
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// start button rectangle, left edge, top edge, width, height
`define GAME_START_X 476
`define GAME_START_Y 400
`define GAME_START_W 72
`define GAME_START_H 72

// target rectangle, a click inside scores a hit
`define GAME_TARGET_X 200
`define GAME_TARGET_Y 160
`define GAME_TARGET_W 96
`define GAME_TARGET_H 96

// round ends on either limit
`define GAME_HITS_TO_WIN 4
`define GAME_MAX_MISSES 3

// hit and miss counter width
`define GAME_SCORE_W 4

// click FIFO depth, must be a power of two
`define GAME_QUEUE_DEPTH 4

`endif

// File: hw/game_pkg.sv
//----------------------------------------------------------
// shared types for the game control subsystem
// click events travel as one packed struct from capture to scorer
// the game state enum is used by the control FSM
//----------------------------------------------------------
package game_pkg;

    //----------------------------------------------------------
    // click event
    //----------------------------------------------------------

    // cursor position latched with a left-button press
    // xpos first, so the x coordinate sits in the upper bits
    typedef struct packed {
        logic [11:0] xpos;
        logic [11:0] ypos;
    } click_event_t;

    //----------------------------------------------------------
    // game state
    //----------------------------------------------------------

    // one screen layer per state
    // START_SCREEN  waits for a click on the start button
    // GAME_RUNNING  clicks go to the scorer
    // GAME_OVER     any click returns to the start screen
    typedef enum logic [1:0] {
        START_SCREEN = 2'b00,
        GAME_RUNNING = 2'b01,
        GAME_OVER    = 2'b10
    } game_state_t;

    // 2'b11 is unused, the FSM falls back to START_SCREEN

endpackage

// File: hw/click_capture.sv
//----------------------------------------------------------
// left-button press capture
// each rising edge of left_mouse becomes one click event
// holding the cursor position sampled with the edge
// presses that find the holding register busy are counted
//----------------------------------------------------------
module click_capture (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  left_mouse,
    input  logic [11:0]           mouse_xpos,
    input  logic [11:0]           mouse_ypos,
    output game_pkg::click_event_t click,
    output logic                  click_valid,
    input  logic                  click_ready,
    output logic [7:0]            dropped_clicks
);

    //----------------------------------------------------------
    // stage 1, button edge and sampled position
    //----------------------------------------------------------

    // previous button level
    logic                   mouse_d;
    // press seen at the last edge
    logic                   press_q;
    // position sampled together with the button
    game_pkg::click_event_t pos_q;
    // holding register free for a new event this cycle
    logic                   slot_free;

    // free when empty or when the held event leaves now
    assign slot_free = !click_valid || click_ready;

    always_ff @(posedge clk) begin
        pos_q.xpos <= mouse_xpos;
        pos_q.ypos <= mouse_ypos;
    end

    //----------------------------------------------------------
    // stage 2, held event and drop counter
    //----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            mouse_d        <= 1'b0;
            press_q        <= 1'b0;
            click_valid    <= 1'b0;
            dropped_clicks <= 8'd0;
        end else begin
            mouse_d <= left_mouse;
            press_q <= left_mouse && !mouse_d;
            if (press_q) begin
                if (slot_free) begin
                    click_valid <= 1'b1;
                end else if (dropped_clicks != 8'hff) begin
                    // held event still waiting, press is lost
                    dropped_clicks <= dropped_clicks + 8'd1;
                end
            end else if (click_valid && click_ready) begin
                click_valid <= 1'b0;
            end
        end
    end

    // payload only loads into a free slot, so it stays stable
    // while valid is high and ready is low
    always_ff @(posedge clk) begin
        if (press_q && slot_free) begin
            click <= pos_q;
        end
    end

endmodule

// File: hw/click_queue.sv
//----------------------------------------------------------
// click event FIFO between capture and control FSM
// holds clicks until the next frame tick lets one out
// a pushed entry becomes visible one cycle after the push
//----------------------------------------------------------
`include "game_params.svh"

module click_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::click_event_t in_event,
    input  logic                   in_valid,
    output logic                   in_ready,
    output game_pkg::click_event_t out_event,
    output logic                   out_valid,
    input  logic                   out_ready
);

    localparam int DEPTH = `GAME_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    //----------------------------------------------------------
    // storage and pointers
    //----------------------------------------------------------

    game_pkg::click_event_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // entries stored, including the one pushed last cycle
    logic [CNT_W-1:0] count;
    // push happened at the last edge
    logic             push_q;
    logic             push;
    logic             pop;

    // full blocks pushes even when a pop happens this cycle
    assign in_ready  = (count != CNT_W'(DEPTH));
    // newest entry stays hidden for one cycle
    assign out_valid = (count > CNT_W'(push_q));
    assign out_event = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_event;
        end
    end

    //----------------------------------------------------------
    // pointer and occupancy update
    //----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            push_q <= 1'b0;
        end else begin
            push_q <= push;
            // pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/game_control_fsm.sv
//----------------------------------------------------------
// game control FSM
// takes at most one queued click per frame tick, moves between
// start screen, running game and game-over screen, drives the
// one-hot layer enables and passes running clicks to the scorer
//----------------------------------------------------------
`include "game_params.svh"

module game_control_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frame_tick,
    input  game_pkg::click_event_t click,
    input  logic                   click_valid,
    output logic                   click_ready,
    input  logic                   round_over,
    output logic                   play_click,
    output game_pkg::click_event_t play_pos,
    output logic                   new_round,
    output logic                   start_screen_enable,
    output logic                   game_enable,
    output logic                   game_end_enable
);

    game_pkg::game_state_t state;
    game_pkg::game_state_t state_next;

    logic in_start;
    logic round_end;
    logic pop;
    logic new_round_next;
    logic play_click_next;

    // start button hit test
    assign in_start = (click.xpos >= 12'(`GAME_START_X)) &&
                      (click.xpos <  12'(`GAME_START_X + `GAME_START_W)) &&
                      (click.ypos >= 12'(`GAME_START_Y)) &&
                      (click.ypos <  12'(`GAME_START_Y + `GAME_START_H));

    // counters of the last round clear on the edge after new_round
    assign round_end = round_over && !new_round;

    // one pop per tick, none while the scorer is still updating,
    // none once the round has ended
    assign click_ready = frame_tick && !play_click && !new_round &&
                         !((state == game_pkg::GAME_RUNNING) && round_end);
    assign pop = click_valid && click_ready;

    //----------------------------------------------------------
    // next state
    //----------------------------------------------------------

    always_comb begin
        state_next      = state;
        new_round_next  = 1'b0;
        play_click_next = 1'b0;
        case (state)
            game_pkg::START_SCREEN: begin
                // clicks outside the button are dropped here
                if (pop && in_start) begin
                    state_next     = game_pkg::GAME_RUNNING;
                    new_round_next = 1'b1;
                end
            end
            game_pkg::GAME_RUNNING: begin
                if (round_end) begin
                    state_next = game_pkg::GAME_OVER;
                end else if (pop) begin
                    play_click_next = 1'b1;
                end
            end
            game_pkg::GAME_OVER: begin
                if (pop) begin
                    state_next = game_pkg::START_SCREEN;
                end
            end
            default: state_next = game_pkg::START_SCREEN;
        endcase
    end

    //----------------------------------------------------------
    // state, enables and pulses
    //----------------------------------------------------------

    // enables decoded from next state, so they change with state
    always_ff @(posedge clk) begin
        if (rst) begin
            state               <= game_pkg::START_SCREEN;
            start_screen_enable <= 1'b1;
            game_enable         <= 1'b0;
            game_end_enable     <= 1'b0;
            new_round           <= 1'b0;
            play_click          <= 1'b0;
        end else begin
            state               <= state_next;
            start_screen_enable <= (state_next == game_pkg::START_SCREEN);
            game_enable         <= (state_next == game_pkg::GAME_RUNNING);
            game_end_enable     <= (state_next == game_pkg::GAME_OVER);
            new_round           <= new_round_next;
            play_click          <= play_click_next;
        end
    end

    // position rides along with play_click
    always_ff @(posedge clk) begin
        if (pop) begin
            play_pos <= click;
        end
    end

endmodule

// File: hw/round_scorer.sv
//----------------------------------------------------------
// round scorer
// sorts each play click into hit or miss against the target
// rectangle and flags the end of the round at either limit
// new_round from the FSM clears both counters
//----------------------------------------------------------
`include "game_params.svh"

module round_scorer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      new_round,
    input  logic                      play_click,
    input  game_pkg::click_event_t    play_pos,
    output logic [`GAME_SCORE_W-1:0]  hits,
    output logic [`GAME_SCORE_W-1:0]  misses,
    output logic                      round_over
);

    localparam int SCORE_W = `GAME_SCORE_W;

    // limits at counter width
    localparam logic [SCORE_W-1:0] HIT_LIMIT  = SCORE_W'(`GAME_HITS_TO_WIN);
    localparam logic [SCORE_W-1:0] MISS_LIMIT = SCORE_W'(`GAME_MAX_MISSES);

    logic in_target;

    //----------------------------------------------------------
    // hit test
    //----------------------------------------------------------

    // left and top edges inside, right and bottom edges outside
    assign in_target = (play_pos.xpos >= 12'(`GAME_TARGET_X)) &&
                       (play_pos.xpos <  12'(`GAME_TARGET_X + `GAME_TARGET_W)) &&
                       (play_pos.ypos >= 12'(`GAME_TARGET_Y)) &&
                       (play_pos.ypos <  12'(`GAME_TARGET_Y + `GAME_TARGET_H));

    // level while either limit is reached
    assign round_over = (hits >= HIT_LIMIT) || (misses >= MISS_LIMIT);

    //----------------------------------------------------------
    // counters
    //----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            hits   <= '0;
            misses <= '0;
        end else if (new_round) begin
            hits   <= '0;
            misses <= '0;
        end else if (play_click && !round_over) begin
            // counters freeze once the round is over
            if (in_target) begin
                hits <= hits + SCORE_W'(1);
            end else begin
                misses <= misses + SCORE_W'(1);
            end
        end
    end

endmodule

// File: hw/game_ctrl_top.sv
//----------------------------------------------------------
// game control top level
// mouse clicks pass capture, FIFO, control FSM and scorer
// frame_tick comes from the VGA timing, one pulse per frame
//----------------------------------------------------------
`include "game_params.svh"

module game_ctrl_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     left_mouse,
    input  logic [11:0]              mouse_xpos,
    input  logic [11:0]              mouse_ypos,
    input  logic                     frame_tick,
    output logic                     start_screen_enable,
    output logic                     game_enable,
    output logic                     game_end_enable,
    output logic [`GAME_SCORE_W-1:0] hits,
    output logic [`GAME_SCORE_W-1:0] misses,
    output logic [7:0]               dropped_clicks
);

    //----------------------------------------------------------
    // internal links
    //----------------------------------------------------------

    // capture to FIFO
    game_pkg::click_event_t cap_event;
    logic                   cap_valid;
    logic                   cap_ready;

    // FIFO to FSM
    game_pkg::click_event_t q_event;
    logic                   q_valid;
    logic                   q_ready;

    // FSM and scorer
    game_pkg::click_event_t play_pos;
    logic                   play_click;
    logic                   new_round;
    logic                   round_over;

    click_capture u_capture (
        .clk            (clk),
        .rst            (rst),
        .left_mouse     (left_mouse),
        .mouse_xpos     (mouse_xpos),
        .mouse_ypos     (mouse_ypos),
        .click          (cap_event),
        .click_valid    (cap_valid),
        .click_ready    (cap_ready),
        .dropped_clicks (dropped_clicks)
    );

    click_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .in_event  (cap_event),
        .in_valid  (cap_valid),
        .in_ready  (cap_ready),
        .out_event (q_event),
        .out_valid (q_valid),
        .out_ready (q_ready)
    );

    game_control_fsm u_fsm (
        .clk                 (clk),
        .rst                 (rst),
        .frame_tick          (frame_tick),
        .click               (q_event),
        .click_valid         (q_valid),
        .click_ready         (q_ready),
        .round_over          (round_over),
        .play_click          (play_click),
        .play_pos            (play_pos),
        .new_round           (new_round),
        .start_screen_enable (start_screen_enable),
        .game_enable         (game_enable),
        .game_end_enable     (game_end_enable)
    );

    round_scorer u_scorer (
        .clk        (clk),
        .rst        (rst),
        .new_round  (new_round),
        .play_click (play_click),
        .play_pos   (play_pos),
        .hits       (hits),
        .misses     (misses),
        .round_over (round_over)
    );

endmodule

// File: verification/game_ctrl_checker.sv
//----------------------------------------------------------
// result checker for the game control testbench
// models each press with a reference function and compares
// enables and counters whenever the DUT outputs move
//----------------------------------------------------------
`include "game_params.svh"

module game_ctrl_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     left_mouse,
    input  logic [11:0]              mouse_xpos,
    input  logic [11:0]              mouse_ypos,
    input  logic                     frame_tick,
    input  logic                     start_screen_enable,
    input  logic                     game_enable,
    input  logic                     game_end_enable,
    input  logic [`GAME_SCORE_W-1:0] hits,
    input  logic [`GAME_SCORE_W-1:0] misses,
    input  logic [7:0]               dropped_clicks,
    input  logic                     drop_check,
    input  logic [7:0]               drop_expected,
    output int                       errors,
    output int                       pending
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCORE_W = `GAME_SCORE_W;
    localparam int OBS_W   = 3 + 2 * SCORE_W;

    // modeled game state and both counters
    typedef struct packed {
        game_pkg::game_state_t st;
        logic [SCORE_W-1:0]    hits;
        logic [SCORE_W-1:0]    misses;
    } model_t;

    // presses not yet consumed by the model
    game_pkg::click_event_t press_q[$];
    model_t                 model;
    logic                   mouse_prev;
    logic [7:0]             drops_prev;
    logic [OBS_W-1:0]       seen;
    // frame ticks since the last compared move
    int                     ticks_seen;

    //----------------------------------------------------------
    // reference model
    //----------------------------------------------------------

    // left and top edges are inside and right and bottom edges are not
    function automatic logic in_rect(int x, int y, int rx, int ry, int rw, int rh);
        return (x >= rx) && (x < rx + rw) && (y >= ry) && (y < ry + rh);
    endfunction

    function automatic model_t apply_click(model_t m, game_pkg::click_event_t c);
        model_t r;
        int     x;
        int     y;
        r = m;
        x = int'(c.xpos);
        y = int'(c.ypos);
        case (m.st)
            game_pkg::START_SCREEN: begin
                if (in_rect(x, y, `GAME_START_X, `GAME_START_Y,
                            `GAME_START_W, `GAME_START_H)) begin
                    r.st     = game_pkg::GAME_RUNNING;
                    r.hits   = '0;
                    r.misses = '0;
                end
            end
            game_pkg::GAME_RUNNING: begin
                if (in_rect(x, y, `GAME_TARGET_X, `GAME_TARGET_Y,
                            `GAME_TARGET_W, `GAME_TARGET_H)) begin
                    r.hits = r.hits + SCORE_W'(1);
                end else begin
                    r.misses = r.misses + SCORE_W'(1);
                end
                // either limit ends the round
                if ((int'(r.hits) >= `GAME_HITS_TO_WIN) ||
                    (int'(r.misses) >= `GAME_MAX_MISSES)) begin
                    r.st = game_pkg::GAME_OVER;
                end
            end
            default: r.st = game_pkg::START_SCREEN;
        endcase
        return r;
    endfunction

    // enables are one-hot by state
    function automatic logic [OBS_W-1:0] expected_outputs(model_t m);
        return {m.st == game_pkg::START_SCREEN, m.st == game_pkg::GAME_RUNNING,
                m.st == game_pkg::GAME_OVER, m.hits, m.misses};
    endfunction

    function automatic logic [OBS_W-1:0] observed_outputs();
        return {start_screen_enable, game_enable, game_end_enable, hits, misses};
    endfunction

    //----------------------------------------------------------
    // comparing
    //----------------------------------------------------------

    task automatic check_value(string name, int got, int exp);
        if (got != exp) begin
            errors = errors + 1;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_value("start_screen_enable", int'(start_screen_enable),
                    int'(model.st == game_pkg::START_SCREEN));
        check_value("game_enable", int'(game_enable),
                    int'(model.st == game_pkg::GAME_RUNNING));
        check_value("game_end_enable", int'(game_end_enable),
                    int'(model.st == game_pkg::GAME_OVER));
        check_value("hits", int'(hits), int'(model.hits));
        check_value("misses", int'(misses), int'(model.misses));
    endtask

    // skip presses the start screen discards and stop at the first that moves
    task automatic advance_model();
        model_t nxt;
        logic   moved;
        moved = 1'b0;
        while (!moved && (press_q.size() > 0)) begin
            nxt   = apply_click(model, press_q.pop_front());
            moved = (expected_outputs(nxt) != expected_outputs(model));
            model = nxt;
        end
        if (!moved) begin
            errors = errors + 1;
            $display("outputs changed but no pending press explains the change");
        end
    endtask

    // press edges, drops and frame ticks sampled at the rising edge
    always @(posedge clk) begin
        if (rst) begin
            mouse_prev <= 1'b0;
            drops_prev <= 8'd0;
        end else begin
            // a drop always hits the newest press
            if (dropped_clicks != drops_prev) begin
                if (press_q.size() == 0) begin
                    errors = errors + 1;
                    $display("a click was dropped although no press was pending");
                end else begin
                    void'(press_q.pop_back());
                end
            end
            if (left_mouse && !mouse_prev) begin
                press_q.push_back({mouse_xpos, mouse_ypos});
            end
            if (frame_tick) begin
                ticks_seen = ticks_seen + 1;
            end
            mouse_prev <= left_mouse;
            drops_prev <= dropped_clicks;
        end
    end

    always @(posedge clk) begin
        if (drop_check) begin
            check_value("dropped_clicks", int'(dropped_clicks), int'(drop_expected));
        end
    end

    always @(negedge clk) begin
        pending = press_q.size();
    end

    initial begin
        errors     = 0;
        ticks_seen = 0;
        model      = '{st: game_pkg::START_SCREEN, hits: '0, misses: '0};
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        @(negedge clk);
        // state right after reset
        compare_outputs();
        seen = observed_outputs();
        forever begin
            @(negedge clk);
            if (observed_outputs() != seen) begin
                // each move pops one click and pops need a frame tick
                if (ticks_seen == 0) begin
                    errors = errors + 1;
                    $display("outputs changed without a frame tick since the last change");
                end
                advance_model();
                // clear, count and game-over settle within three edges
                repeat (3) @(negedge clk);
                compare_outputs();
                seen       = observed_outputs();
                ticks_seen = 0;
            end
        end
    end

endmodule

// File: verification/game_ctrl_tb.sv
//----------------------------------------------------------
// testbench for the game control top level
// drives presses, frame ticks and reset while the checker compares
//----------------------------------------------------------
`include "game_params.svh"

module game_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_CLICKS  = 26;
    localparam int PRESS_GAP = 20;
    // reset, per-click budget and margin
    localparam int TIMEOUT_CYCLES = 8 + N_CLICKS * 40 + 500;

    logic                     clk;
    logic                     rst;
    logic                     left_mouse;
    logic [11:0]              mouse_xpos;
    logic [11:0]              mouse_ypos;
    logic                     frame_tick;
    logic                     start_screen_enable;
    logic                     game_enable;
    logic                     game_end_enable;
    logic [`GAME_SCORE_W-1:0] hits;
    logic [`GAME_SCORE_W-1:0] misses;
    logic [7:0]               dropped_clicks;
    logic                     tick_on;
    logic                     drop_check;
    logic [7:0]               drop_expected;
    logic [31:0]              rng_state;
    int                       errors;
    int                       pending;

    always #2 clk = ~clk;

    game_ctrl_top UUT (
        .clk (clk), .rst (rst), .left_mouse (left_mouse),
        .mouse_xpos (mouse_xpos), .mouse_ypos (mouse_ypos), .frame_tick (frame_tick),
        .start_screen_enable (start_screen_enable), .game_enable (game_enable),
        .game_end_enable (game_end_enable), .hits (hits), .misses (misses),
        .dropped_clicks (dropped_clicks)
    );

    game_ctrl_checker u_checker (
        .clk (clk), .rst (rst), .left_mouse (left_mouse),
        .mouse_xpos (mouse_xpos), .mouse_ypos (mouse_ypos), .frame_tick (frame_tick),
        .start_screen_enable (start_screen_enable), .game_enable (game_enable),
        .game_end_enable (game_end_enable), .hits (hits), .misses (misses),
        .dropped_clicks (dropped_clicks), .drop_check (drop_check),
        .drop_expected (drop_expected), .errors (errors), .pending (pending)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // one press at a random point of a rectangle followed by idle cycles
    task automatic press_area(int rx, int ry, int rw, int rh, int gap);
        int x;
        int y;
        rng_state = xorshift32(rng_state);
        x = rx + int'(rng_state % 32'(rw));
        rng_state = xorshift32(rng_state);
        y = ry + int'(rng_state % 32'(rh));
        @(negedge clk);
        mouse_xpos = 12'(x);
        mouse_ypos = 12'(y);
        left_mouse = 1'b1;
        repeat (2) @(negedge clk);
        left_mouse = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // one press inside the target rectangle
    task automatic press_target(int gap);
        press_area(`GAME_TARGET_X, `GAME_TARGET_Y, `GAME_TARGET_W, `GAME_TARGET_H, gap);
    endtask

    // frame tick every 16 cycles while enabled
    initial begin
        frame_tick = 1'b0;
        forever begin
            repeat (15) @(negedge clk);
            frame_tick = tick_on && !rst;
            @(negedge clk);
            frame_tick = 1'b0;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        left_mouse    = 1'b0;
        mouse_xpos    = 12'd0;
        mouse_ypos    = 12'd0;
        tick_on       = 1'b1;
        drop_check    = 1'b0;
        drop_expected = 8'd0;
        rng_state     = 32'd51621;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        // presses outside the start button and then one inside
        repeat (3) press_area(0, 0, 400, 400, PRESS_GAP);
        press_area(`GAME_START_X, `GAME_START_Y, `GAME_START_W, `GAME_START_H, PRESS_GAP);
        // fourth hit wins the round and the next press returns to start
        repeat (3) press_target(PRESS_GAP);
        repeat (2) press_area(0, 300, 600, 300, PRESS_GAP);
        repeat (2) press_target(PRESS_GAP);
        // new round lost on misses and then back to start
        press_area(`GAME_START_X, `GAME_START_Y, `GAME_START_W, `GAME_START_H, PRESS_GAP);
        repeat (4) press_area(0, 300, 600, 300, PRESS_GAP);
        wait (pending == 0);
        repeat (20) @(negedge clk);
        //------------------------------------------------------------
        // back-pressure with frame ticks held off
        //------------------------------------------------------------
        tick_on = 1'b0;
        press_area(`GAME_START_X, `GAME_START_Y, `GAME_START_W, `GAME_START_H, 6);
        press_target(6);
        repeat (8) press_area(0, 300, 600, 300, 6);
        repeat (10) @(negedge clk);
        drop_expected = 8'(10 - `GAME_QUEUE_DEPTH - 1);
        drop_check = 1'b1;
        @(negedge clk);
        drop_check = 1'b0;
        tick_on = 1'b1;
        wait (pending == 0);
        repeat (8) @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: game_ctrl_top.f
+incdir+hw
hw/game_pkg.sv
hw/click_capture.sv
hw/click_queue.sv
hw/game_control_fsm.sv
hw/round_scorer.sv
hw/game_ctrl_top.sv
verification/game_ctrl_checker.sv
verification/game_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the game control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module game_ctrl_tb \
    -f game_ctrl_top.f -o sim_game_ctrl

out=$(./obj_dir/sim_game_ctrl)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi
